// File: Bender.yml
package:
  name: slink_deskew

sources:
  - files:
      - slink_deskew_pkg.sv
      - lane_capture.sv
      - deskew_control.sv
      - lane_align.sv
      - os_detect.sv
      - slink_deskew.sv
  - target: test
    files:
      - slink_deskew_asserts.sv
      - slink_deskew_tb.sv

// File: deskew_control.sv
`default_nettype none

module deskew_control (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            enable,
  input  slink_deskew_pkg::lane_cfg_t     active_lanes,
  input  slink_deskew_pkg::lane_mask_t    rx_locked,
  input  logic [slink_deskew_pkg::FIFO_DEPTH-1:0] sync_hits [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::lane_mask_t    lane_active,
  output slink_deskew_pkg::lane_mask_t    capture_en,
  output slink_deskew_pkg::fifo_idx_t     read_ptr [slink_deskew_pkg::NUM_LANES],
  output logic                            locked,
  output slink_deskew_pkg::deskew_state_e deskew_state
);

  slink_deskew_pkg::deskew_state_e state;
  slink_deskew_pkg::deskew_state_e state_next;
  slink_deskew_pkg::fifo_idx_t     hit_idx [slink_deskew_pkg::NUM_LANES];
  slink_deskew_pkg::lane_mask_t    one_hot;
  slink_deskew_pkg::lane_mask_t    lane_ok;
  logic                            all_lanes_ok;
  logic                            lock_now;

  // --------------------------------------------------
  // Lane mask
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      lane_active[i] = (i < (1 << active_lanes));
    end
  end

  assign capture_en = lane_active & rx_locked & {slink_deskew_pkg::NUM_LANES{enable}};

  // Each lane must see exactly one sync byte in its window
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      hit_idx[i] = '0;
      for (int k = 0; k < slink_deskew_pkg::FIFO_DEPTH; k++) begin
        if (sync_hits[i][k]) begin
          hit_idx[i] = slink_deskew_pkg::fifo_idx_t'(k);
        end
      end
      one_hot[i] = (sync_hits[i] != '0) &&
                   ((sync_hits[i] & (sync_hits[i] - 1'b1)) == '0);
    end
  end

  assign lane_ok      = one_hot | ~lane_active;
  assign all_lanes_ok = &lane_ok;
  assign lock_now     = (state == slink_deskew_pkg::TRAIN) && all_lanes_ok && enable;

  // --------------------------------------------------
  // Training FSM
  // --------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      slink_deskew_pkg::IDLE: begin
        if (enable) begin
          state_next = slink_deskew_pkg::TRAIN;
        end
      end
      slink_deskew_pkg::TRAIN: begin
        if (all_lanes_ok) begin
          state_next = slink_deskew_pkg::LOCKED;
        end
      end
      slink_deskew_pkg::LOCKED: begin
        state_next = slink_deskew_pkg::LOCKED;
      end
      default: begin
        state_next = slink_deskew_pkg::IDLE;
      end
    endcase
    if (!enable) begin
      state_next = slink_deskew_pkg::IDLE;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= slink_deskew_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Pointers load on the lock edge and hold until enable drops
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
        read_ptr[i] <= '0;
      end
    end else begin
      for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
        if (!enable) begin
          read_ptr[i] <= '0;
        end else if (lock_now) begin
          read_ptr[i] <= lane_active[i] ? hit_idx[i] : '0;
        end
      end
    end
  end

  assign locked       = (state == slink_deskew_pkg::LOCKED);
  assign deskew_state = state;

endmodule

`default_nettype wire

// File: lane_align.sv
`default_nettype none

module lane_align (
  input  slink_deskew_pkg::lane_entry_t entries
    [slink_deskew_pkg::NUM_LANES][slink_deskew_pkg::FIFO_DEPTH],
  input  slink_deskew_pkg::fifo_idx_t   read_ptr [slink_deskew_pkg::NUM_LANES],
  input  slink_deskew_pkg::lane_mask_t  lane_active,
  output slink_deskew_pkg::byte_t       rx_data_out [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::lane_mask_t  rx_valid_out,
  output slink_deskew_pkg::lane_mask_t  rx_start_block_out,
  output slink_deskew_pkg::sync_hdr_t   rx_sync_hdr_out [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::fifo_idx_t   fifo_ptr_status [slink_deskew_pkg::NUM_LANES]
);

  slink_deskew_pkg::lane_entry_t sel [slink_deskew_pkg::NUM_LANES];

  // --------------------------------------------------
  // Read each line at its locked position
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      if (lane_active[i]) begin
        sel[i] = entries[i][read_ptr[i]];
      end else begin
        sel[i] = '0;
      end
    end
  end

  // Unpack; inactive lanes already forced to zero above
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      rx_data_out[i]        = sel[i].data;
      rx_valid_out[i]       = sel[i].valid;
      rx_start_block_out[i] = sel[i].start_block;
      rx_sync_hdr_out[i]    = sel[i].sync_hdr;
      fifo_ptr_status[i]    = lane_active[i] ? read_ptr[i] : '0;
    end
  end

endmodule

`default_nettype wire

// File: lane_capture.sv
`default_nettype none

module lane_capture (
  input  logic                           clk,
  input  logic                           reset,
  input  slink_deskew_pkg::lane_mask_t   capture_en,
  input  slink_deskew_pkg::byte_t        rx_data_in [slink_deskew_pkg::NUM_LANES],
  input  slink_deskew_pkg::lane_mask_t   rx_valid_in,
  input  slink_deskew_pkg::lane_mask_t   rx_start_block_in,
  input  slink_deskew_pkg::sync_hdr_t    rx_sync_hdr_in [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::lane_entry_t  entries
    [slink_deskew_pkg::NUM_LANES][slink_deskew_pkg::FIFO_DEPTH],
  output logic [slink_deskew_pkg::FIFO_DEPTH-1:0] sync_hits [slink_deskew_pkg::NUM_LANES]
);

  slink_deskew_pkg::lane_entry_t lane_in [slink_deskew_pkg::NUM_LANES];

  // Pack each lane's inputs into one entry
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      lane_in[i].valid       = rx_valid_in[i];
      lane_in[i].start_block = rx_start_block_in[i];
      lane_in[i].sync_hdr    = rx_sync_hdr_in[i];
      lane_in[i].data        = rx_data_in[i];
    end
  end

  // --------------------------------------------------
  // Shift lines
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
        for (int k = 0; k < slink_deskew_pkg::FIFO_DEPTH; k++) begin
          entries[i][k] <= '0;
        end
      end
    end else begin
      for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
        if (capture_en[i]) begin
          entries[i][0] <= lane_in[i];
          for (int k = 1; k < slink_deskew_pkg::FIFO_DEPTH; k++) begin
            entries[i][k] <= entries[i][k-1];
          end
        end else begin
          // Flush the line while the lane is off
          for (int k = 0; k < slink_deskew_pkg::FIFO_DEPTH; k++) begin
            entries[i][k] <= '0;
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Sync control byte match per entry
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      for (int k = 0; k < slink_deskew_pkg::FIFO_DEPTH; k++) begin
        sync_hits[i][k] = entries[i][k].valid &&
                          entries[i][k].start_block &&
                          (entries[i][k].sync_hdr == slink_deskew_pkg::SH_CTRL) &&
                          (entries[i][k].data == slink_deskew_pkg::SYNC_BYTE);
      end
    end
  end

endmodule

`default_nettype wire

// File: os_detect.sv
`default_nettype none

module os_detect (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         locked,
  input  slink_deskew_pkg::lane_mask_t lane_active,
  input  slink_deskew_pkg::byte_t      rx_data_out [slink_deskew_pkg::NUM_LANES],
  input  slink_deskew_pkg::lane_mask_t rx_valid_out,
  input  slink_deskew_pkg::lane_mask_t rx_start_block_out,
  input  slink_deskew_pkg::sync_hdr_t  rx_sync_hdr_out [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::lane_mask_t rx_ts1_seen,
  output slink_deskew_pkg::lane_mask_t rx_ts2_seen,
  output slink_deskew_pkg::lane_mask_t rx_sds_seen
);

  slink_deskew_pkg::os_count_t  ts1_count      [slink_deskew_pkg::NUM_LANES];
  slink_deskew_pkg::os_count_t  ts2_count      [slink_deskew_pkg::NUM_LANES];
  slink_deskew_pkg::os_count_t  sds_count      [slink_deskew_pkg::NUM_LANES];
  slink_deskew_pkg::os_count_t  ts1_count_next [slink_deskew_pkg::NUM_LANES];
  slink_deskew_pkg::os_count_t  ts2_count_next [slink_deskew_pkg::NUM_LANES];
  slink_deskew_pkg::os_count_t  sds_count_next [slink_deskew_pkg::NUM_LANES];
  slink_deskew_pkg::lane_mask_t ctrl_start;

  // Counts a control-start first byte followed by repeat bytes
  function automatic slink_deskew_pkg::os_count_t next_count(
    input slink_deskew_pkg::os_count_t count,
    input logic                        start,
    input slink_deskew_pkg::byte_t     data,
    input slink_deskew_pkg::byte_t     first_byte,
    input slink_deskew_pkg::byte_t     repeat_byte
  );
    slink_deskew_pkg::os_count_t result;
    if (count == '0) begin
      result = (start && (data == first_byte)) ? 4'd1 : 4'd0;
    end else begin
      result = (data == repeat_byte) ? count + 4'd1 : 4'd0;
    end
    return result;
  endfunction

  // --------------------------------------------------
  // Counter update
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      ctrl_start[i] = rx_valid_out[i] && rx_start_block_out[i] &&
                      (rx_sync_hdr_out[i] == slink_deskew_pkg::SH_CTRL);
      if (locked) begin
        ts1_count_next[i] = next_count(ts1_count[i], ctrl_start[i], rx_data_out[i],
                                       slink_deskew_pkg::TS1_BYTE0,
                                       slink_deskew_pkg::TS1_BYTEX);
        ts2_count_next[i] = next_count(ts2_count[i], ctrl_start[i], rx_data_out[i],
                                       slink_deskew_pkg::TS2_BYTE0,
                                       slink_deskew_pkg::TS2_BYTEX);
        sds_count_next[i] = next_count(sds_count[i], ctrl_start[i], rx_data_out[i],
                                       slink_deskew_pkg::SDS_BYTE0,
                                       slink_deskew_pkg::SDS_BYTEX);
      end else begin
        ts1_count_next[i] = '0;
        ts2_count_next[i] = '0;
        sds_count_next[i] = '0;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
        ts1_count[i] <= '0;
        ts2_count[i] <= '0;
        sds_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
        ts1_count[i] <= ts1_count_next[i];
        ts2_count[i] <= ts2_count_next[i];
        sds_count[i] <= sds_count_next[i];
      end
    end
  end

  // Inactive lanes read high so a consumer can AND across lanes
  always_comb begin
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      rx_ts1_seen[i] = !lane_active[i] || (ts1_count[i] == slink_deskew_pkg::OS_SEEN_COUNT);
      rx_ts2_seen[i] = !lane_active[i] || (ts2_count[i] == slink_deskew_pkg::OS_SEEN_COUNT);
      rx_sds_seen[i] = !lane_active[i] || (sds_count[i] == slink_deskew_pkg::OS_SEEN_COUNT);
    end
  end

endmodule

`default_nettype wire

// File: slink_deskew.f
slink_deskew_pkg.sv
lane_capture.sv
deskew_control.sv
lane_align.sv
os_detect.sv
slink_deskew.sv
slink_deskew_asserts.sv
slink_deskew_tb.sv

// File: slink_deskew.sv
`default_nettype none

module slink_deskew (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            enable,
  input  slink_deskew_pkg::lane_cfg_t     active_lanes,
  input  slink_deskew_pkg::byte_t         rx_data_in [slink_deskew_pkg::NUM_LANES],
  input  slink_deskew_pkg::lane_mask_t    rx_valid_in,
  input  slink_deskew_pkg::lane_mask_t    rx_start_block_in,
  input  slink_deskew_pkg::lane_mask_t    rx_locked,
  input  slink_deskew_pkg::sync_hdr_t     rx_sync_hdr_in [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::byte_t         rx_data_out [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::lane_mask_t    rx_valid_out,
  output slink_deskew_pkg::lane_mask_t    rx_start_block_out,
  output slink_deskew_pkg::sync_hdr_t     rx_sync_hdr_out [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::fifo_idx_t     fifo_ptr_status [slink_deskew_pkg::NUM_LANES],
  output slink_deskew_pkg::lane_mask_t    rx_ts1_seen,
  output slink_deskew_pkg::lane_mask_t    rx_ts2_seen,
  output slink_deskew_pkg::lane_mask_t    rx_sds_seen,
  output slink_deskew_pkg::deskew_state_e deskew_state
);

  slink_deskew_pkg::lane_mask_t  capture_en;
  slink_deskew_pkg::lane_mask_t  lane_active;
  slink_deskew_pkg::fifo_idx_t   read_ptr [slink_deskew_pkg::NUM_LANES];
  logic                          locked;
  slink_deskew_pkg::lane_entry_t entries
    [slink_deskew_pkg::NUM_LANES][slink_deskew_pkg::FIFO_DEPTH];
  logic [slink_deskew_pkg::FIFO_DEPTH-1:0] sync_hits [slink_deskew_pkg::NUM_LANES];

  // --------------------------------------------------
  // Input side
  // --------------------------------------------------
  lane_capture lane_capture_i (
    .clk               (clk),
    .reset             (reset),
    .capture_en        (capture_en),
    .rx_data_in        (rx_data_in),
    .rx_valid_in       (rx_valid_in),
    .rx_start_block_in (rx_start_block_in),
    .rx_sync_hdr_in    (rx_sync_hdr_in),
    .entries           (entries),
    .sync_hits         (sync_hits)
  );

  // --------------------------------------------------
  // Training and lock
  // --------------------------------------------------
  deskew_control deskew_control_i (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .active_lanes (active_lanes),
    .rx_locked    (rx_locked),
    .sync_hits    (sync_hits),
    .lane_active  (lane_active),
    .capture_en   (capture_en),
    .read_ptr     (read_ptr),
    .locked       (locked),
    .deskew_state (deskew_state)
  );

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  lane_align lane_align_i (
    .entries            (entries),
    .read_ptr           (read_ptr),
    .lane_active        (lane_active),
    .rx_data_out        (rx_data_out),
    .rx_valid_out       (rx_valid_out),
    .rx_start_block_out (rx_start_block_out),
    .rx_sync_hdr_out    (rx_sync_hdr_out),
    .fifo_ptr_status    (fifo_ptr_status)
  );

  // Ordered sets are looked for on the aligned lanes
  os_detect os_detect_i (
    .clk                (clk),
    .reset              (reset),
    .locked             (locked),
    .lane_active        (lane_active),
    .rx_data_out        (rx_data_out),
    .rx_valid_out       (rx_valid_out),
    .rx_start_block_out (rx_start_block_out),
    .rx_sync_hdr_out    (rx_sync_hdr_out),
    .rx_ts1_seen        (rx_ts1_seen),
    .rx_ts2_seen        (rx_ts2_seen),
    .rx_sds_seen        (rx_sds_seen)
  );

endmodule

`default_nettype wire

// File: slink_deskew_asserts.sv
`default_nettype none

module slink_deskew_asserts (
  input logic                            clk,
  input logic                            reset,
  input slink_deskew_pkg::deskew_state_e deskew_state,
  input slink_deskew_pkg::fifo_idx_t     read_ptr [slink_deskew_pkg::NUM_LANES],
  input slink_deskew_pkg::lane_mask_t    lane_active,
  input logic [slink_deskew_pkg::FIFO_DEPTH-1:0] sync_hits [slink_deskew_pkg::NUM_LANES]
);

  int                                       fail_count = 0;
  logic [2*slink_deskew_pkg::NUM_LANES-1:0] ptr_flat;
  logic                                     hits_ok;

  // Flat pointer word and per-lane one-hot qualification
  always_comb begin
    hits_ok = 1'b1;
    for (int i = 0; i < slink_deskew_pkg::NUM_LANES; i++) begin
      ptr_flat[2*i +: 2] = read_ptr[i];
      if (lane_active[i] && !$onehot(sync_hits[i])) begin
        hits_ok = 1'b0;
      end
    end
  end

  state_legal: assert property (@(posedge clk) disable iff (reset)
    deskew_state inside {slink_deskew_pkg::IDLE, slink_deskew_pkg::TRAIN,
                         slink_deskew_pkg::LOCKED})
    else begin
      fail_count++;
      $error("deskew_state holds an illegal encoding");
    end

  ptr_frozen: assert property (@(posedge clk) disable iff (reset)
    (deskew_state == slink_deskew_pkg::LOCKED) |=>
      (deskew_state != slink_deskew_pkg::LOCKED) || $stable(ptr_flat))
    else begin
      fail_count++;
      $error("read pointers moved while locked");
    end

  lock_one_hit: assert property (@(posedge clk) disable iff (reset)
    (deskew_state != slink_deskew_pkg::LOCKED) ##1
      (deskew_state == slink_deskew_pkg::LOCKED) |-> $past(hits_ok))
    else begin
      fail_count++;
      $error("lock taken without exactly one sync hit per active lane");
    end

endmodule

bind deskew_control slink_deskew_asserts asserts_i (
  .clk          (clk),
  .reset        (reset),
  .deskew_state (deskew_state),
  .read_ptr     (read_ptr),
  .lane_active  (lane_active),
  .sync_hits    (sync_hits)
);

`default_nettype wire

// File: slink_deskew_pkg.sv
`default_nettype none

package slink_deskew_pkg;

  // --------------------------------------------------
  // Link geometry
  // --------------------------------------------------
  localparam int NUM_LANES  = 4;
  localparam int FIFO_DEPTH = 4;

  // --------------------------------------------------
  // Protocol values
  // --------------------------------------------------
  localparam logic [1:0] SH_CTRL   = 2'b10;
  localparam logic [1:0] SH_DATA   = 2'b01;
  localparam logic [7:0] SYNC_BYTE = 8'hBC;

  localparam logic [7:0] TS1_BYTE0 = 8'h2D;
  localparam logic [7:0] TS1_BYTEX = 8'h4A;
  localparam logic [7:0] TS2_BYTE0 = 8'h2E;
  localparam logic [7:0] TS2_BYTEX = 8'h45;
  localparam logic [7:0] SDS_BYTE0 = 8'h3C;
  localparam logic [7:0] SDS_BYTEX = 8'h55;

  // First byte plus fourteen repeats
  localparam logic [3:0] OS_SEEN_COUNT = 4'd15;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  typedef logic [7:0] byte_t;
  typedef logic [1:0] sync_hdr_t;
  typedef logic [1:0] fifo_idx_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;
  typedef logic [3:0] os_count_t;

  // 0 is one lane, 1 is two lanes, 2 is four lanes
  typedef logic [1:0] lane_cfg_t;

  typedef struct packed {
    logic      valid;
    logic      start_block;
    sync_hdr_t sync_hdr;
    byte_t     data;
  } lane_entry_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    TRAIN  = 2'd1,
    LOCKED = 2'd2
  } deskew_state_e;

endpackage

`default_nettype wire

// File: slink_deskew_tb.sv
`default_nettype none

module slink_deskew_tb;

  typedef slink_deskew_pkg::byte_t         byte_t;
  typedef slink_deskew_pkg::sync_hdr_t     sync_hdr_t;
  typedef slink_deskew_pkg::fifo_idx_t     fifo_idx_t;
  typedef slink_deskew_pkg::lane_mask_t    lane_mask_t;
  typedef slink_deskew_pkg::lane_cfg_t     lane_cfg_t;
  typedef slink_deskew_pkg::lane_entry_t   lane_entry_t;
  typedef slink_deskew_pkg::deskew_state_e deskew_state_e;

  localparam int NL           = slink_deskew_pkg::NUM_LANES;
  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ROWS     = 6;
  localparam int OS_REPEATS   = 14;
  localparam int TAIL_LEN     = 4;

  localparam logic [1:0] KIND_TS1    = 2'd0;
  localparam logic [1:0] KIND_TS2    = 2'd1;
  localparam logic [1:0] KIND_SDS    = 2'd2;
  localparam logic [1:0] KIND_BROKEN = 2'd3;

  // Skews and expected pointers hold lane 3 in the top two bits
  typedef struct packed {
    lane_cfg_t  cfg;
    logic [7:0] skews;
    logic [7:0] exp_ptrs;
    logic [1:0] kind;
    logic [3:0] payload;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{2'd2, {2'd3, 2'd2, 2'd1, 2'd0}, {2'd0, 2'd1, 2'd2, 2'd3}, KIND_TS1,    4'd5},
    '{2'd1, {2'd1, 2'd3, 2'd0, 2'd2}, {2'd0, 2'd0, 2'd2, 2'd0}, KIND_TS2,    4'd3},
    '{2'd0, {2'd0, 2'd3, 2'd2, 2'd1}, {2'd0, 2'd0, 2'd0, 2'd0}, KIND_SDS,    4'd2},
    '{2'd2, {2'd0, 2'd3, 2'd1, 2'd2}, {2'd3, 2'd0, 2'd2, 2'd1}, KIND_BROKEN, 4'd4},
    '{2'd2, {2'd1, 2'd1, 2'd1, 2'd1}, {2'd0, 2'd0, 2'd0, 2'd0}, KIND_SDS,    4'd6},
    '{2'd1, {2'd2, 2'd1, 2'd3, 2'd0}, {2'd0, 2'd0, 2'd0, 2'd3}, KIND_TS1,    4'd1}
  };

  logic          clk;
  logic          reset;
  logic          enable;
  lane_cfg_t     active_lanes;
  byte_t         rx_data_in [NL];
  lane_mask_t    rx_valid_in;
  lane_mask_t    rx_start_block_in;
  lane_mask_t    rx_locked;
  sync_hdr_t     rx_sync_hdr_in [NL];
  byte_t         rx_data_out [NL];
  lane_mask_t    rx_valid_out;
  lane_mask_t    rx_start_block_out;
  sync_hdr_t     rx_sync_hdr_out [NL];
  fifo_idx_t     fifo_ptr_status [NL];
  lane_mask_t    rx_ts1_seen;
  lane_mask_t    rx_ts2_seen;
  lane_mask_t    rx_sds_seen;
  deskew_state_e deskew_state;

  // Reference stream shared by all lanes before skew
  lane_entry_t   seq_q [$];

  slink_deskew dut_i (
    .clk                (clk),
    .reset              (reset),
    .enable             (enable),
    .active_lanes       (active_lanes),
    .rx_data_in         (rx_data_in),
    .rx_valid_in        (rx_valid_in),
    .rx_start_block_in  (rx_start_block_in),
    .rx_locked          (rx_locked),
    .rx_sync_hdr_in     (rx_sync_hdr_in),
    .rx_data_out        (rx_data_out),
    .rx_valid_out       (rx_valid_out),
    .rx_start_block_out (rx_start_block_out),
    .rx_sync_hdr_out    (rx_sync_hdr_out),
    .fifo_ptr_status    (fifo_ptr_status),
    .rx_ts1_seen        (rx_ts1_seen),
    .rx_ts2_seen        (rx_ts2_seen),
    .rx_sds_seen        (rx_sds_seen),
    .deskew_state       (deskew_state)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_ROWS * 200 * CLK_PERIOD);
    $display("timeout: the tests did not finish within the watchdog limit");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_hdr(input string name, input sync_hdr_t expected,
                           input sync_hdr_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_idx(input string name, input fifo_idx_t expected,
                           input fifo_idx_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_mask(input string name, input lane_mask_t expected,
                            input lane_mask_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_state(input string name, input deskew_state_e expected,
                             input deskew_state_e actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic lane_mask_t active_mask(input lane_cfg_t cfg);
    case (cfg)
      2'd0:    return 4'b0001;
      2'd1:    return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // Random data byte that never looks like a protocol byte
  function automatic byte_t filler_byte();
    byte_t b;
    b = byte_t'($urandom);
    while (b inside {slink_deskew_pkg::SYNC_BYTE, slink_deskew_pkg::TS1_BYTE0,
                     slink_deskew_pkg::TS1_BYTEX, slink_deskew_pkg::TS2_BYTE0,
                     slink_deskew_pkg::TS2_BYTEX, slink_deskew_pkg::SDS_BYTE0,
                     slink_deskew_pkg::SDS_BYTEX}) begin
      b = byte_t'($urandom);
    end
    return b;
  endfunction

  function automatic lane_entry_t make_entry(input logic valid, input logic start,
                                             input sync_hdr_t hdr, input byte_t data);
    lane_entry_t e;
    e.valid       = valid;
    e.start_block = start;
    e.sync_hdr    = hdr;
    e.data        = data;
    return e;
  endfunction

  // Sync block, payload, one ordered set, then a short tail
  task automatic build_sequence(input logic [1:0] kind, input int payload);
    byte_t first;
    byte_t rep;
    case (kind)
      KIND_TS1: begin
        first = slink_deskew_pkg::TS1_BYTE0;
        rep   = slink_deskew_pkg::TS1_BYTEX;
      end
      KIND_SDS: begin
        first = slink_deskew_pkg::SDS_BYTE0;
        rep   = slink_deskew_pkg::SDS_BYTEX;
      end
      default: begin
        first = slink_deskew_pkg::TS2_BYTE0;
        rep   = slink_deskew_pkg::TS2_BYTEX;
      end
    endcase
    seq_q.delete();
    seq_q.push_back(make_entry(1'b1, 1'b1, slink_deskew_pkg::SH_CTRL,
                               slink_deskew_pkg::SYNC_BYTE));
    for (int j = 0; j < payload; j++) begin
      seq_q.push_back(make_entry(1'b1, j == 0, slink_deskew_pkg::SH_DATA, filler_byte()));
    end
    seq_q.push_back(make_entry(1'b1, 1'b1, slink_deskew_pkg::SH_CTRL, first));
    for (int j = 0; j < OS_REPEATS; j++) begin
      if (kind == KIND_BROKEN && j == 6) begin
        seq_q.push_back(make_entry(1'b1, 1'b0, slink_deskew_pkg::SH_CTRL, filler_byte()));
      end else begin
        seq_q.push_back(make_entry(1'b1, 1'b0, slink_deskew_pkg::SH_CTRL, rep));
      end
    end
    for (int j = 0; j < TAIL_LEN; j++) begin
      seq_q.push_back(make_entry(1'b1, 1'b0, slink_deskew_pkg::SH_DATA, filler_byte()));
    end
  endtask

  task automatic drive_idle();
    for (int i = 0; i < NL; i++) begin
      rx_data_in[i]        = '0;
      rx_valid_in[i]       = 1'b0;
      rx_start_block_in[i] = 1'b0;
      rx_sync_hdr_in[i]    = '0;
    end
  endtask

  // Lane i carries the reference stream late by its skew
  task automatic drive_slot(input row_t row, input int t);
    int          idx;
    lane_entry_t e;
    for (int i = 0; i < NL; i++) begin
      idx = t - int'(row.skews[2*i +: 2]);
      e   = '0;
      if (idx >= 0 && idx < seq_q.size()) begin
        e = seq_q[idx];
      end
      rx_data_in[i]        = e.data;
      rx_valid_in[i]       = e.valid;
      rx_start_block_in[i] = e.start_block;
      rx_sync_hdr_in[i]    = e.sync_hdr;
    end
  endtask

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------
  task automatic check_cycle(input row_t row, input lane_mask_t act, input int max_skew,
                             input int t);
    int            idx;
    logic          now_locked;
    logic          seen_now;
    lane_entry_t   e;
    lane_mask_t    exp_valid;
    lane_mask_t    exp_start;
    fifo_idx_t     exp_ptr;
    deskew_state_e exp_state;
    now_locked = (t >= max_skew + 2);
    idx        = t - 1 - max_skew;
    exp_state  = now_locked ? slink_deskew_pkg::LOCKED : slink_deskew_pkg::TRAIN;
    check_state("deskew_state", exp_state, deskew_state);
    e = '0;
    if (now_locked && idx < seq_q.size()) begin
      e = seq_q[idx];
    end
    exp_valid = e.valid ? act : '0;
    exp_start = e.start_block ? act : '0;
    for (int i = 0; i < NL; i++) begin
      exp_ptr = (now_locked && act[i]) ? fifo_idx_t'(row.exp_ptrs[2*i +: 2]) : '0;
      check_idx($sformatf("fifo_ptr_status[%0d]", i), exp_ptr, fifo_ptr_status[i]);
      if (now_locked) begin
        check_byte($sformatf("rx_data_out[%0d]", i), act[i] ? e.data : '0, rx_data_out[i]);
        check_hdr($sformatf("rx_sync_hdr_out[%0d]", i), act[i] ? e.sync_hdr : '0,
                  rx_sync_hdr_out[i]);
      end
    end
    if (now_locked) begin
      check_mask("rx_valid_out", exp_valid, rx_valid_out);
      check_mask("rx_start_block_out", exp_start, rx_start_block_out);
    end
    // Flag holds for the one cycle after the last repeat leaves the output
    seen_now = now_locked && (idx == int'(row.payload) + 2 + OS_REPEATS);
    check_mask("rx_ts1_seen", ~act | ((seen_now && row.kind == KIND_TS1) ? act : '0),
               rx_ts1_seen);
    check_mask("rx_ts2_seen", ~act | ((seen_now && row.kind == KIND_TS2) ? act : '0),
               rx_ts2_seen);
    check_mask("rx_sds_seen", ~act | ((seen_now && row.kind == KIND_SDS) ? act : '0),
               rx_sds_seen);
  endtask

  task automatic run_row(input row_t row);
    lane_mask_t act;
    int         max_skew;
    int         last_t;
    act      = active_mask(row.cfg);
    max_skew = 0;
    for (int i = 0; i < NL; i++) begin
      if (act[i] && int'(row.skews[2*i +: 2]) > max_skew) begin
        max_skew = int'(row.skews[2*i +: 2]);
      end
    end
    build_sequence(row.kind, int'(row.payload));
    @(posedge clk);
    #DRIVE_DELAY;
    enable = 1'b0;
    drive_idle();
    @(posedge clk);
    #DRIVE_DELAY;
    enable       = 1'b1;
    active_lanes = row.cfg;
    @(negedge clk);
    check_state("deskew_state", slink_deskew_pkg::IDLE, deskew_state);
    for (int i = 0; i < NL; i++) begin
      check_idx($sformatf("fifo_ptr_status[%0d]", i), '0, fifo_ptr_status[i]);
    end
    last_t = max_skew + seq_q.size() + 1;
    for (int t = 0; t <= last_t; t++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drive_slot(row, t);
      @(negedge clk);
      check_cycle(row, act, max_skew, t);
    end
  endtask

  task automatic check_after_reset();
    check_state("deskew_state", slink_deskew_pkg::IDLE, deskew_state);
    for (int i = 0; i < NL; i++) begin
      check_byte($sformatf("rx_data_out[%0d]", i), '0, rx_data_out[i]);
      check_hdr($sformatf("rx_sync_hdr_out[%0d]", i), '0, rx_sync_hdr_out[i]);
      check_idx($sformatf("fifo_ptr_status[%0d]", i), '0, fifo_ptr_status[i]);
    end
    check_mask("rx_valid_out", '0, rx_valid_out);
    check_mask("rx_start_block_out", '0, rx_start_block_out);
    check_mask("rx_ts1_seen", ~active_mask(active_lanes), rx_ts1_seen);
    check_mask("rx_ts2_seen", ~active_mask(active_lanes), rx_ts2_seen);
    check_mask("rx_sds_seen", ~active_mask(active_lanes), rx_sds_seen);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(32'h95a2));
    reset        = 1'b1;
    enable       = 1'b0;
    active_lanes = 2'd2;
    rx_locked    = '1;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clk);
    check_after_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(ROWS[r]);
    end
    @(posedge clk);
    if (dut_i.deskew_control_i.asserts_i.fail_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("assertion failures in deskew_control: %0d",
               dut_i.deskew_control_i.asserts_i.fail_count);
      $display("sim failed");
      $fatal(1, "assertion failures seen");
    end
  end

endmodule

`default_nettype wire
